// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_uart_rx
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
uart_rx_pkg.sv
uart_baud_tick.sv
uart_rx_sampler.sv
uart_rx_frame.sv
uart_rx_top.sv
tb_uart_rx.sv

// ==== tb_uart_rx.sv ====
// Testbench for the UART receiver: drives a serial line model and checks each byte at handshake
`timescale 1ns/10ps
`default_nettype none

module tb_uart_rx;
    import uart_rx_pkg::*;

    // One bit and one frame on the line, in clock cycles
    localparam int bit_cycles   = ticks_per_bit * clks_per_tick;
    localparam int frame_cycles = (data_bits + 2) * bit_cycles;

    // Start edge to rx_valid window
    localparam int lat_min = 600;
    localparam int lat_max = 640;

    // Sampler sees rxd as driven at bit offsets 25, 29, 33, 37 and 41
    localparam int glitch_in_off  = 33;
    localparam int glitch_out_off = 50;

    // Stop bit offsets that cover the cycle in which the DUT loads a new byte
    localparam int load_first = 38;
    localparam int load_last  = 43;

    // Frames sent, with the quiet window and held idle counted as frames
    localparam int frame_total     = 50;
    localparam int watchdog_cycles = frame_total * 700 + 5000;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 rxd;
    logic                 rx_ready = 1'b0;
    logic [data_bits-1:0] rx_data;
    logic                 rx_valid;
    logic                 rx_frame_err;
    logic                 rx_noise;
    logic                 rx_overrun;

    // Consumer mode: 0 random, 1 held low, 2 held high
    logic [1:0]  ready_mode = 2'd0;
    logic [31:0] ready_rng = 32'ha5e5b819;
    logic [31:0] data_rng = 32'ha5e5b819;

    int errors = 0;
    int cycle = 0;
    int edge_cycle = 0;
    bit stop_sampling = 1'b0;
    bit quiet = 1'b0;

    // Expected bytes as {overrun, noise, frame_err, data}
    logic [10:0]          exp_q[$];
    logic                 exp_known = 1'b0;
    logic [data_bits-1:0] exp_data = '0;
    logic                 exp_fe = 1'b0;
    logic                 exp_noise = 1'b0;
    logic                 exp_ovr = 1'b0;

    uart_rx_top uart_rx_top_inst (
        .clk          (clk),
        .reset        (reset),
        .rxd          (rxd),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .rx_noise     (rx_noise),
        .rx_overrun   (rx_overrun)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Numerical Recipes LCG
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Consumer side
    always @(posedge clk) begin
        ready_rng <= lcg_next(ready_rng);
        case (ready_mode)
            2'd0:    rx_ready <= ready_rng[16];
            2'd1:    rx_ready <= 1'b0;
            default: rx_ready <= 1'b1;
        endcase
    end

    // Queue head follows each handshake
    always @(posedge clk) begin
        if (!reset && rx_valid && rx_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        if (exp_q.size() > 0) begin
            exp_known <= 1'b1;
            {exp_ovr, exp_noise, exp_fe, exp_data} <= exp_q[0];
        end else begin
            exp_known <= 1'b0;
        end
    end

    task automatic random_byte(output logic [7:0] b);
        data_rng = lcg_next(data_rng);
        b = data_rng[23:16];
    endtask

    task automatic expect_byte(input logic [7:0] data, input logic fe, input logic noise,
                               input logic ovr);
        exp_q.push_back({ovr, noise, fe, data});
    endtask

    // Line model, one frame of start, 8 data bits LSB first and stop
    // glitch_bit counts the start bit as 0, and -1 means a clean frame
    task automatic send_frame(input logic [7:0] data, input bit bad_stop, input int glitch_bit,
                              input int glitch_off, input int gap);
        logic [9:0] bits;
        logic       v;
        int         i;
        int         c;
        bits = {~bad_stop, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            for (c = 0; c < bit_cycles; c++) begin
                v = bits[i] ^ (i == glitch_bit && c == glitch_off);
                if (i == 0 && c == 0) begin
                    edge_cycle = cycle;
                end
                stop_sampling = (i == 9 && c >= load_first && c <= load_last);
                rxd <= v;
                @(posedge clk);
            end
        end
        stop_sampling = 1'b0;
        // Idle gap lets a low stop bit end before the next start edge
        if (gap > 0) begin
            rxd <= 1'b1;
            repeat (gap) @(posedge clk);
        end
    endtask

    // Short low pulse on an idle line
    task automatic short_low(input int len);
        rxd <= 1'b0;
        repeat (len) @(posedge clk);
        rxd <= 1'b1;
        @(posedge clk);
    endtask

    // Wait until every expected byte has been taken and rx_valid is low
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || rx_valid) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (n >= limit) begin
            errors++;
            $display("Timed out waiting for delivery, %0d expected bytes left", exp_q.size());
        end
    endtask

    // Handshake checks against the queue head
    a_expected: assert property (@(posedge clk) disable iff (reset)
        rx_valid && rx_ready |-> exp_known)
        else begin
            errors++;
            $display("A byte was delivered that no frame was sent for, at cycle %0d", cycle);
        end

    a_data: assert property (@(posedge clk) disable iff (reset)
        rx_valid && rx_ready && exp_known |-> rx_data == exp_data)
        else begin
            errors++;
            $display("ERROR rx_data: got %h expected %h", $sampled(rx_data), $sampled(exp_data));
        end

    a_frame_err: assert property (@(posedge clk) disable iff (reset)
        rx_valid && rx_ready && exp_known |-> rx_frame_err == exp_fe)
        else begin
            errors++;
            $display("ERROR rx_frame_err: got %h expected %h", $sampled(rx_frame_err),
                     $sampled(exp_fe));
        end

    a_noise: assert property (@(posedge clk) disable iff (reset)
        rx_valid && rx_ready && exp_known |-> rx_noise == exp_noise)
        else begin
            errors++;
            $display("ERROR rx_noise: got %h expected %h", $sampled(rx_noise),
                     $sampled(exp_noise));
        end

    a_overrun: assert property (@(posedge clk) disable iff (reset)
        rx_valid && rx_ready && exp_known |-> rx_overrun == exp_ovr)
        else begin
            errors++;
            $display("ERROR rx_overrun: got %h expected %h", $sampled(rx_overrun),
                     $sampled(exp_ovr));
        end

    // Stalled output holds unless the DUT is loading the next frame
    a_hold: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready && !stop_sampling |=>
            $stable(rx_data) && $stable(rx_frame_err) && $stable(rx_noise) &&
            $stable(rx_overrun) && rx_valid)
        else begin
            errors++;
            $display("Output changed while rx_ready was low, at cycle %0d", cycle);
        end

    a_drop: assert property (@(posedge clk) disable iff (reset)
        rx_valid && rx_ready && !stop_sampling |=> !rx_valid)
        else begin
            errors++;
            $display("ERROR rx_valid: got %h expected %h after handshake", 1'b1, 1'b0);
        end

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        quiet |-> !rx_valid)
        else begin
            errors++;
            $display("A short low pulse on the idle line produced a byte, at cycle %0d", cycle);
        end

    a_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(rx_valid) |-> (cycle - edge_cycle >= lat_min) && (cycle - edge_cycle <= lat_max))
        else begin
            errors++;
            $display("ERROR rx_valid latency: got %h cycles, window %h to %h",
                     $sampled(cycle - edge_cycle), lat_min, lat_max);
        end

    initial begin : stimulus
        logic [7:0] b;
        int         n;
        rxd   = 1'b1;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (8) @(posedge clk);

        // Random bytes on a clean line, consumer ready at random
        for (n = 0; n < 40; n++) begin
            random_byte(b);
            expect_byte(b, 1'b0, 1'b0, 1'b0);
            send_frame(b, 1'b0, -1, 0, 0);
        end
        wait_drain(frame_cycles);

        // Stop bit sent as 0
        random_byte(b);
        expect_byte(b, 1'b1, 1'b0, 1'b0);
        send_frame(b, 1'b1, -1, 0, 16);
        wait_drain(frame_cycles);

        // Glitch on a sample of data bit 3, then one between samples
        random_byte(b);
        expect_byte(b, 1'b0, 1'b1, 1'b0);
        send_frame(b, 1'b0, 4, glitch_in_off, 0);
        random_byte(b);
        expect_byte(b, 1'b0, 1'b0, 1'b0);
        send_frame(b, 1'b0, 4, glitch_out_off, 0);
        wait_drain(frame_cycles);

        // False start, then a clean frame
        quiet = 1'b1;
        short_low(10);
        repeat (2 * frame_cycles) @(posedge clk);
        quiet = 1'b0;
        random_byte(b);
        expect_byte(b, 1'b0, 1'b0, 1'b0);
        send_frame(b, 1'b0, -1, 0, 0);
        wait_drain(frame_cycles);

        // Consumer stalls, first byte held, then replaced by the second
        ready_mode <= 2'd1;
        random_byte(b);
        send_frame(b, 1'b0, -1, 0, 400);
        random_byte(b);
        expect_byte(b, 1'b0, 1'b0, 1'b1);
        send_frame(b, 1'b0, -1, 0, 0);
        ready_mode <= 2'd2;
        wait_drain(frame_cycles);

        // Overrun clears with the handshake
        ready_mode <= 2'd0;
        random_byte(b);
        expect_byte(b, 1'b0, 1'b0, 1'b0);
        send_frame(b, 1'b0, -1, 0, 0);
        wait_drain(frame_cycles);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the stimulus ended", watchdog_cycles);
        $display("Errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_baud_tick.sv ====
// Free-running 16x baud sample tick generator that the frame controller re-phases
`timescale 1ns/10ps
`default_nettype none

module uart_baud_tick (
    input  wire  clk,
    input  wire  reset,
    input  wire  tick_sync,
    output logic sample_tick
);
    import uart_rx_pkg::*;

    logic [$clog2(clks_per_tick)-1:0] cnt;

    // Divider counter
    // tick_sync restarts the count so the tick grid follows the start edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (tick_sync) begin
            cnt <= '0;
        end else if (int'(cnt) == clks_per_tick - 1) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One-cycle pulse on the last count of each period
    assign sample_tick = (int'(cnt) == clks_per_tick - 1);

    // Tick is a single-cycle pulse
    a_tick_single: assert property (@(posedge clk) disable iff (reset)
        sample_tick |=> !sample_tick);

endmodule

`default_nettype wire

// ==== uart_rx_frame.sv ====
// Line synchronizer and frame FSM that turns the serial line into bytes for uart_rx_top
`timescale 1ns/10ps
`default_nettype none

module uart_rx_frame (
    input  wire  clk,
    input  wire  reset,
    input  wire  rxd,
    input  wire  sample_tick,
    input  wire  bit_done,
    input  wire  bit_value,
    input  wire  bit_stable,
    input  wire  rx_ready,
    output logic tick_sync,
    output logic bit_start,
    output logic rxd_sync,
    output logic [uart_rx_pkg::data_bits-1:0] rx_data,
    output logic rx_valid,
    output logic rx_frame_err,
    output logic rx_noise,
    output logic rx_overrun
);
    import uart_rx_pkg::*;

    frame_state_t state;

    // Synchronizer and edge detect
    logic sync_q1;
    logic rxd_prev;
    logic fall;

    // Bit pacing
    logic start_q;
    logic next_bit;
    logic [$clog2(ticks_per_bit)-1:0] tick_cnt;
    logic [$clog2(data_bits)-1:0]     bit_idx;

    // Frame assembly
    logic [data_bits-1:0] shift_q;
    logic                 noise_q;
    logic                 load;

    // Two-flop synchronizer plus one more stage for edge detection
    // Idle line is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1  <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            sync_q1  <= rxd;
            rxd_sync <= sync_q1;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall = rxd_prev & ~rxd_sync;

    // Start pulse comes one cycle after the edge and also resyncs the tick grid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= (state == RX_IDLE) && fall;
        end
    end

    // Tick index within the current bit
    // The resync cycle itself is tick 0 and its stale tick is ignored
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (state == RX_IDLE) begin
            tick_cnt <= '0;
        end else if (sample_tick && !start_q) begin
            if (int'(tick_cnt) == ticks_per_bit - 1) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // Tick 16 of a bit is tick 0 of the next
    // Only data and stop bits follow on
    assign next_bit  = sample_tick && (int'(tick_cnt) == ticks_per_bit - 1) &&
                       (state == RX_DATA || state == RX_STOP);
    assign bit_start = start_q | next_bit;
    assign tick_sync = start_q;

    assign load = (state == RX_STOP) && bit_done;

    // Frame FSM advanced on each bit result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= RX_IDLE;
            bit_idx <= '0;
            noise_q <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state   <= RX_START;
                        noise_q <= 1'b0;
                    end
                end
                RX_START: begin
                    if (bit_done) begin
                        noise_q <= noise_q | ~bit_stable;
                        bit_idx <= '0;
                        // A start bit voted high is a glitch and not a frame
                        state   <= bit_value ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        noise_q <= noise_q | ~bit_stable;
                        bit_idx <= bit_idx + 1'b1;
                        if (int'(bit_idx) == data_bits - 1) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // Back to idle mid stop bit so a new start can follow at once
                    if (bit_done) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB first so new bits enter at the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            shift_q <= {bit_value, shift_q[data_bits-1:1]};
        end
        if (load) begin
            rx_data <= shift_q;
        end
    end

    // Output handshake and status flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
            rx_noise     <= 1'b0;
            rx_overrun   <= 1'b0;
        end else if (load) begin
            rx_valid     <= 1'b1;
            rx_frame_err <= ~bit_value;
            rx_noise     <= noise_q | ~bit_stable;
            // Unread byte is being overwritten
            rx_overrun   <= rx_valid & ~rx_ready;
        end else if (rx_valid && rx_ready) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end
    end

    // Output held while the consumer stalls unless a new frame lands
    a_hold_output: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready && !load |=>
            $stable(rx_data) && $stable(rx_frame_err) &&
            $stable(rx_noise) && $stable(rx_overrun) && rx_valid);

    // Later bits begin on a tick one bit period after the bit before
    a_start_on_tick: assert property (@(posedge clk) disable iff (reset)
        bit_start && !tick_sync |->
            sample_tick && $past(bit_start, ticks_per_bit * clks_per_tick));

endmodule

`default_nettype wire

// ==== uart_rx_pkg.sv ====
// Shared timing constants and FSM state types for the UART receiver and its testbench
`default_nettype none

package uart_rx_pkg;

    // Clock cycles between two sample ticks
    localparam integer clks_per_tick = 4;

    // Sample ticks in one bit period (16x oversampling)
    localparam int ticks_per_bit = 16;

    // Tick index of the first vote sample, counted from bit start
    localparam int sample_first = 6;

    // Votes per bit, centred on tick 8
    localparam int sample_count = 5;

    // Data bits per frame, sent LSB first
    localparam int data_bits = 8;

    // Bit sampler states
    typedef enum logic [1:0] {
        SMP_LOCK    = 2'b00,  // idle after reset, waiting for the first bit
        SMP_WAIT    = 2'b01,  // counting ticks towards the sample window
        SMP_COLLECT = 2'b10,  // taking one sample per tick
        SMP_HOLD    = 2'b11   // result held until the next bit
    } sampler_state_t;

    // Frame controller states
    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,  // line idle, watching for a falling edge
        RX_START = 2'b01,  // checking the start bit
        RX_DATA  = 2'b10,  // shifting in data bits
        RX_STOP  = 2'b11   // checking the stop bit
    } frame_state_t;

endpackage

`default_nettype wire

// ==== uart_rx_sampler.sv ====
// Per-bit sampler: woken by bit_start, votes on five ticked samples and flags unstable bits
`timescale 1ns/10ps
`default_nettype none

module uart_rx_sampler (
    input  wire  clk,
    input  wire  reset,
    input  wire  sample_tick,
    input  wire  bit_start,
    input  wire  rxd_sync,
    output logic bit_done,
    output logic bit_value,
    output logic bit_stable
);
    import uart_rx_pkg::*;

    sampler_state_t state;

    // Ticks seen since bit_start, and the index of the current tick
    logic [$clog2(ticks_per_bit)-1:0] tick_cnt;
    logic [$clog2(ticks_per_bit)-1:0] tick_idx;

    // Vote accumulation
    logic [2:0] ones;
    logic [2:0] ones_next;
    logic       prev_sample;
    logic       differed;
    logic       differed_next;
    logic       first_tick;
    logic       last_tick;

    // Result of the last completed bit
    logic       value_q;
    logic       stable_q;

    assign tick_idx   = tick_cnt + 1'b1;
    assign first_tick = (int'(tick_idx) == sample_first);
    assign last_tick  = (state == SMP_COLLECT) && sample_tick &&
                        (int'(tick_idx) == sample_first + sample_count - 1);

    // Running count including the sample on this tick
    assign ones_next = ones + {2'b00, rxd_sync};
    // First sample has nothing to compare against
    assign differed_next = differed | (!first_tick && (rxd_sync != prev_sample));

    // Control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= SMP_LOCK;
            tick_cnt <= '0;
        end else if (bit_start) begin
            // bit_start is tick 0 of the new bit
            state    <= SMP_WAIT;
            tick_cnt <= '0;
        end else if (sample_tick) begin
            case (state)
                SMP_WAIT: begin
                    tick_cnt <= tick_idx;
                    // Next tick opens the sample window
                    if (int'(tick_idx) == sample_first - 1) begin
                        state <= SMP_COLLECT;
                    end
                end
                SMP_COLLECT: begin
                    tick_cnt <= tick_idx;
                    if (last_tick) begin
                        state <= SMP_HOLD;
                    end
                end
                default: begin
                    // LOCK and HOLD just wait for bit_start
                end
            endcase
        end
    end

    // Sample datapath
    always_ff @(posedge clk) begin
        if (state == SMP_WAIT) begin
            ones     <= '0;
            differed <= 1'b0;
        end else if (state == SMP_COLLECT && sample_tick) begin
            ones        <= ones_next;
            differed    <= differed_next;
            prev_sample <= rxd_sync;
        end
        if (last_tick) begin
            value_q  <= (int'(ones_next) > sample_count / 2);
            stable_q <= !differed_next;
        end
    end

    // Result is presented on the last sample tick, then held from the registers
    assign bit_done   = last_tick;
    assign bit_value  = last_tick ? (int'(ones_next) > sample_count / 2) : value_q;
    assign bit_stable = last_tick ? !differed_next : stable_q;

    // bit_done never stretches
    a_done_single: assert property (@(posedge clk) disable iff (reset)
        bit_done |=> !bit_done);

    // Frame controller never restarts a bit that is still being sampled
    a_no_early_start: assert property (@(posedge clk) disable iff (reset)
        bit_start |-> (state == SMP_LOCK || state == SMP_HOLD));

endmodule

`default_nettype wire

// ==== uart_rx_top.sv ====
// UART receiver top level, connecting tick generator, bit sampler and frame controller
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top (
    input  wire  clk,
    input  wire  reset,
    // Serial input, idle high
    input  wire  rxd,
    // Consumer side
    input  wire  rx_ready,
    output wire  [uart_rx_pkg::data_bits-1:0] rx_data,
    output wire  rx_valid,
    output wire  rx_frame_err,
    output wire  rx_noise,
    output wire  rx_overrun
);

    // 16x tick and its resync from the start edge
    wire sample_tick;
    wire tick_sync;

    // Per-bit handshake between frame controller and sampler
    wire bit_start;
    wire bit_done;
    wire bit_value;
    wire bit_stable;

    // Synchronized serial line
    wire rxd_sync;

    uart_baud_tick uart_baud_tick_inst (
        .clk         (clk),
        .reset       (reset),
        .tick_sync   (tick_sync),
        .sample_tick (sample_tick)
    );

    uart_rx_sampler uart_rx_sampler_inst (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .bit_start   (bit_start),
        .rxd_sync    (rxd_sync),
        .bit_done    (bit_done),
        .bit_value   (bit_value),
        .bit_stable  (bit_stable)
    );

    uart_rx_frame uart_rx_frame_inst (
        .clk          (clk),
        .reset        (reset),
        .rxd          (rxd),
        .sample_tick  (sample_tick),
        .bit_done     (bit_done),
        .bit_value    (bit_value),
        .bit_stable   (bit_stable),
        .rx_ready     (rx_ready),
        .tick_sync    (tick_sync),
        .bit_start    (bit_start),
        .rxd_sync     (rxd_sync),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .rx_noise     (rx_noise),
        .rx_overrun   (rx_overrun)
    );

endmodule

`default_nettype wire
